// ==== bench/cfgTopTb.sv ====
`timescale 1ns/1ps
`include "cfg_defs.svh"

module cfgTopTb;

    localparam int ClkPeriod  = 20;
    localparam int W          = `FRAME_BITS_PER_ROW;
    localparam int F          = `MAX_FRAMES_PER_COL;
    localparam int Rows       = `NUMBER_OF_ROWS;
    localparam int Cols       = `NUMBER_OF_COLS;
    localparam int SW         = `FRAME_SELECT_WIDTH;
    localparam int FD         = `FRAME_DATA_WIDTH;
    localparam int FS         = `FRAME_STROBE_WIDTH;
    // upper bound on words sent by the sequence below
    localparam int WordBudget = 80;

    logic          CLK;
    logic          reset;
    logic [W-1:0]  configWord;
    logic          configValid;
    logic [FD-1:0] frameData;
    logic [FS-1:0] frameStrobe;
    logic          synced;

    logic [15:0]   lfsrState;
    int            strobeCount;
    logic [FS-1:0] lastStrobe;

    // reference model state
    logic          modelSynced;
    logic          modelExpectAddress;
    logic [W-1:0]  modelAddress;
    logic [W-1:0]  modelRows [Rows];
    int            modelRow;
    int            modelStrobeCount;
    logic [FS-1:0] modelLastStrobe;

    cfgTop u_cfgTop (
        .CLK        (CLK),
        .reset      (reset),
        .configWord (configWord),
        .configValid(configValid),
        .frameData  (frameData),
        .frameStrobe(frameStrobe),
        .synced     (synced)
    );

    initial begin
        CLK = 1'b0;
        forever #(ClkPeriod/2) CLK = ~CLK;
    end

    // strobe pulses counted on the falling edge
    always @(negedge CLK) begin
        if (reset) begin
            strobeCount <= 0;
            lastStrobe  <= '0;
        end else if (|frameStrobe) begin
            strobeCount <= strobeCount + 1;
            lastStrobe  <= frameStrobe;
        end
    end

    task automatic failRun();
        $display("Some tests failed");
        $fatal(1, "stopping at first error");
    endtask

    initial begin
        #((WordBudget * 20 + 200) * ClkPeriod);
        $display("watchdog expired before the test sequence finished");
        failRun();
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrState[0]};
            lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 16'hB400 : 16'h0000);
        end
        return v;
    endfunction

    function automatic logic [W-1:0] addressWord(input int col, input bit desync);
        logic [W-1:0] w;
        w = takeBits(W);
        w[W-1 -: SW] = col[SW-1:0];
        w[`DESYNC_BIT] = desync;
        // keeps the strobe pattern non-empty
        w[0] = 1'b1;
        return w;
    endfunction

    function automatic logic [FD-1:0] expectedFrameData();
        logic [FD-1:0] v;
        v = '0;
        v[0 +: W] = `GUARD_WORD;
        for (int r = 0; r < Rows; r++) begin
            v[(r+1)*W +: W] = modelRows[r];
        end
        v[(Rows+1)*W +: W] = `GUARD_WORD;
        return v;
    endfunction

    // protocol rule applied to one accepted word
    task automatic modelWord(input logic [W-1:0] w);
        int           colSel;
        logic [F-1:0] bits;
        if (!modelSynced) begin
            if (w == `SYNC_WORD) begin
                modelSynced        = 1'b1;
                modelExpectAddress = 1'b1;
            end
        end else if (modelExpectAddress) begin
            if (w[`DESYNC_BIT]) begin
                modelSynced = 1'b0;
            end else begin
                modelAddress       = w;
                modelExpectAddress = 1'b0;
                modelRow           = 0;
            end
        end else begin
            modelRows[modelRow] = w;
            modelRow++;
            if (modelRow == Rows) begin
                modelExpectAddress = 1'b1;
                colSel = int'(modelAddress[W-1 -: SW]);
                bits   = modelAddress[F-1:0];
                if (colSel < Cols) begin
                    modelStrobeCount++;
                    modelLastStrobe = '0;
                    modelLastStrobe[colSel*F +: F] = bits;
                end
            end
        end
    endtask

    task automatic sendWord(input logic [W-1:0] w, input bit withGaps);
        int gap;
        gap = withGaps ? int'(takeBits(2)) : 0;
        repeat (gap) begin
            @(posedge CLK);
            configValid <= 1'b0;
            configWord  <= takeBits(W);
        end
        @(posedge CLK);
        configWord  <= w;
        configValid <= 1'b1;
        modelWord(w);
    endtask

    task automatic checkValue(input string name, input logic [FD-1:0] got,
                              input logic [FD-1:0] want);
        assert (got === want) else begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, want);
            failRun();
        end
    endtask

    task automatic settleAndCheck();
        @(posedge CLK);
        configValid <= 1'b0;
        // wait for the frame strobe if one is due
        for (int i = 0; i < 10 && strobeCount != modelStrobeCount; i++) begin
            @(negedge CLK);
        end
        repeat (3) @(negedge CLK);
        checkValue("synced", FD'(synced), FD'(modelSynced));
        checkValue("frameData", frameData, expectedFrameData());
        checkValue("strobeCount", FD'(strobeCount), FD'(modelStrobeCount));
        checkValue("frameStrobe", FD'(lastStrobe), FD'(modelLastStrobe));
    endtask

    task automatic sendFrame(input int col, input bit withGaps);
        sendWord(addressWord(col, 1'b0), withGaps);
        repeat (Rows) sendWord(takeBits(W), withGaps);
        settleAndCheck();
    endtask

    initial begin
        reset       <= 1'b1;
        configWord  <= '0;
        configValid <= 1'b0;
        lfsrState = 16'd33922;
        modelSynced = 1'b0;
        modelExpectAddress = 1'b0;
        modelAddress = '0;
        modelRow = 0;
        modelStrobeCount = 0;
        modelLastStrobe = '0;
        for (int r = 0; r < Rows; r++) begin
            modelRows[r] = '0;
        end
        repeat (5) @(posedge CLK);
        reset <= 1'b0;
        settleAndCheck();

        // words before sync are ignored
        sendWord(addressWord(0, 1'b0), 1'b0);
        repeat (3) sendWord(takeBits(W), 1'b0);
        sendWord(addressWord(1, 1'b1), 1'b0);
        settleAndCheck();

        sendWord(`SYNC_WORD, 1'b0);
        settleAndCheck();

        // back to back words on every column
        for (int c = 0; c < Cols; c++) begin
            sendFrame(c, 1'b0);
        end

        // gaps in configValid inside the frame
        repeat (3) sendFrame(int'(takeBits(3)) % Cols, 1'b1);

        // column select past the last column
        sendFrame(Cols, 1'b0);
        sendFrame(31, 1'b1);

        // desync drops everything up to the next sync
        sendWord(addressWord(2, 1'b1), 1'b0);
        settleAndCheck();
        sendWord(addressWord(1, 1'b0), 1'b0);
        repeat (3) sendWord(takeBits(W), 1'b1);
        settleAndCheck();
        sendWord(`SYNC_WORD, 1'b1);
        sendFrame(3, 1'b1);

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== bench/cfgTop_checker.sv ====
`timescale 1ns/1ps
`include "cfg_defs.svh"

module cfgTop_checker (
    input logic                           CLK,
    input logic                           reset,
    input logic [`FRAME_DATA_WIDTH-1:0]   frameData,
    input logic [`FRAME_STROBE_WIDTH-1:0] frameStrobe,
    input logic                           synced
);

    localparam int W    = `FRAME_BITS_PER_ROW;
    localparam int Rows = `NUMBER_OF_ROWS;

    // a finished frame fires its column for one cycle only
    strobeSinglePulse: assert property (
        @(posedge CLK) disable iff (reset)
        (|frameStrobe) |=> !(|frameStrobe)
    ) else $error("frameStrobe stayed high for two cycles");

    // no column strobe without sync
    strobeOnlyWhenSynced: assert property (
        @(posedge CLK) disable iff (reset)
        !synced |-> (frameStrobe == '0)
    ) else $error("frameStrobe high while synced is low");

    // bottom and top guard words
    guardWordsFixed: assert property (
        @(posedge CLK)
        (frameData[0 +: W] == `GUARD_WORD) &&
        (frameData[(Rows+1)*W +: W] == `GUARD_WORD)
    ) else $error("guard word on frameData changed");

endmodule

bind cfgTop cfgTop_checker u_cfgTopChecker (
    .CLK        (CLK),
    .reset      (reset),
    .frameData  (frameData),
    .frameStrobe(frameStrobe),
    .synced     (synced)
);

// ==== project.f ====
+incdir+src
src/cfgPkg.sv
src/frameWriteIf.sv
src/frameWriteCtrl.sv
src/frameDataRegs.sv
src/frameSelectDecode.sv
src/cfgTop.sv
bench/cfgTop_checker.sv
bench/cfgTopTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cfgTop testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f project.f \
    --top-module cfgTopTb \
    -o cfgTopTbSim

./obj_dir/cfgTopTbSim

// ==== src/cfgPkg.sv ====
`include "cfg_defs.svh"

package cfgPkg;

    // bits between colSelect and the desync flag
    localparam int ReservedWidth =
        `FRAME_BITS_PER_ROW - `FRAME_SELECT_WIDTH - `DESYNC_BIT - 1;

    // frame address word, msb first
    // colSelect 31..27, desync at DESYNC_BIT, frameBits 19..0
    typedef struct packed {
        logic [`FRAME_SELECT_WIDTH-1:0] colSelect;
        logic [ReservedWidth-1:0]       reserved;
        logic                           desync;
        logic [`MAX_FRAMES_PER_COL-1:0] frameBits;
    } frameAddressT;

    // one incoming word, read as row data or as a frame address
    typedef union packed {
        logic [`FRAME_BITS_PER_ROW-1:0] raw;
        frameAddressT                   addr;
    } cfgWordT;

    // one-hot row enable
    typedef logic [`NUMBER_OF_ROWS-1:0] rowSelectT;

endpackage

// ==== src/cfgTop.sv ====
`timescale 1ns/1ps
`include "cfg_defs.svh"

module cfgTop (
    input  logic                            CLK,
    input  logic                            reset,
    input  logic [`FRAME_BITS_PER_ROW-1:0]  configWord,
    input  logic                            configValid,
    output logic [`FRAME_DATA_WIDTH-1:0]    frameData,
    output logic [`FRAME_STROBE_WIDTH-1:0]  frameStrobe,
    output logic                            synced
);

    cfgPkg::cfgWordT cfgWordIn;

    // incoming word as the union the controller decodes
    assign cfgWordIn = configWord;

    // frame write from controller to rows and columns
    frameWriteIf wr ();

    frameWriteCtrl u_frameWriteCtrl (
        .CLK        (CLK),
        .reset      (reset),
        .configWord (cfgWordIn),
        .configValid(configValid),
        .synced     (synced),
        .wr         (wr.ctrl)
    );

    frameDataRegs u_frameDataRegs (
        .CLK      (CLK),
        .reset    (reset),
        .wr       (wr.rows),
        .frameData(frameData)
    );

    frameSelectDecode u_frameSelectDecode (
        .wr         (wr.cols),
        .frameStrobe(frameStrobe)
    );

endmodule

// ==== src/cfg_defs.svh ====
`ifndef CFG_DEFS_SVH
`define CFG_DEFS_SVH

// fabric geometry
`define NUMBER_OF_ROWS      4
`define NUMBER_OF_COLS      5

// one row register, also the width of a configuration word
`define FRAME_BITS_PER_ROW  32

// strobe bits per column, same width as the frameBits field
`define MAX_FRAMES_PER_COL  20

// frame address word fields
`define FRAME_SELECT_WIDTH  5
`define DESYNC_BIT          20

// special words
`define SYNC_WORD           32'hFAB0FAB1
`define GUARD_WORD          32'h12345678

// bus widths at the top level
// guard word above and below the rows
`define FRAME_DATA_WIDTH    ((`NUMBER_OF_ROWS + 2) * `FRAME_BITS_PER_ROW)
`define FRAME_STROBE_WIDTH  (`NUMBER_OF_COLS * `MAX_FRAMES_PER_COL)

`endif

// ==== src/frameDataRegs.sv ====
`timescale 1ns/1ps
`include "cfg_defs.svh"

module frameDataRegs (
    input  logic                         CLK,
    input  logic                         reset,
    frameWriteIf.rows                    wr,
    output logic [`FRAME_DATA_WIDTH-1:0] frameData
);

    localparam int W = `FRAME_BITS_PER_ROW;

    logic [W-1:0] rowReg [`NUMBER_OF_ROWS];

    genvar r;
    generate
        for (r = 0; r < `NUMBER_OF_ROWS; r = r + 1) begin : g_row
            // one frame register per fabric row
            always_ff @(posedge CLK) begin
                if (reset) begin
                    rowReg[r] <= '0;
                end else if (wr.rowSelect[r]) begin
                    rowReg[r] <= wr.writeData.raw;
                end
            end

            // row 0 sits just above the bottom guard
            assign frameData[(r+1)*W +: W] = rowReg[r];
        end
    endgenerate

    // guard words around the rows
    assign frameData[0 +: W]                      = `GUARD_WORD;
    assign frameData[(`NUMBER_OF_ROWS+1)*W +: W] = `GUARD_WORD;

endmodule

// ==== src/frameSelectDecode.sv ====
`timescale 1ns/1ps
`include "cfg_defs.svh"

module frameSelectDecode (
    frameWriteIf.cols                      wr,
    output logic [`FRAME_STROBE_WIDTH-1:0] frameStrobe
);

    localparam int F = `MAX_FRAMES_PER_COL;

    logic [`FRAME_SELECT_WIDTH-1:0] colSelect;
    logic [F-1:0]                   frameBits;
    logic [`NUMBER_OF_COLS-1:0]     colHit;

    // address fields of the held frame address word
    assign colSelect = wr.frameAddress.addr.colSelect;
    assign frameBits = wr.frameAddress.addr.frameBits;

    genvar c;
    generate
        for (c = 0; c < `NUMBER_OF_COLS; c = c + 1) begin : g_col
            // colSelect beyond the last column never matches
            assign colHit[c] = wr.longFrameStrobe &&
                               (colSelect == `FRAME_SELECT_WIDTH'(c));

            assign frameStrobe[c*F +: F] = colHit[c] ? frameBits : '0;
        end
    endgenerate

endmodule

// ==== src/frameWriteCtrl.sv ====
`timescale 1ns/1ps
`include "cfg_defs.svh"

module frameWriteCtrl (
    input  logic            CLK,
    input  logic            reset,
    input  cfgPkg::cfgWordT configWord,
    input  logic            configValid,
    output logic            synced,
    frameWriteIf.ctrl       wr
);

    localparam int RowCountWidth = $clog2(`NUMBER_OF_ROWS);
    localparam logic [RowCountWidth-1:0] LastRow = RowCountWidth'(`NUMBER_OF_ROWS - 1);

    typedef enum logic [1:0] {
        StUnsynced,
        StExpectAddress,
        StLoadData
    } stateT;

    stateT                    state;
    logic [RowCountWidth-1:0] rowCount;
    logic                     isSyncWord;
    logic                     isDesync;
    logic                     acceptData;
    logic                     acceptAddress;

    // word decode, same word seen both ways
    assign isSyncWord = (configWord.raw == `SYNC_WORD);
    assign isDesync   = configWord.addr.desync;

    assign acceptData    = configValid && (state == StLoadData);
    assign acceptAddress = configValid && (state == StExpectAddress) && !isDesync;

    assign synced = (state != StUnsynced);

    always_ff @(posedge CLK) begin
        if (reset) begin
            state              <= StUnsynced;
            rowCount           <= '0;
            wr.rowSelect       <= '0;
            wr.longFrameStrobe <= 1'b0;
        end else begin
            // row select only lives for one cycle
            wr.rowSelect <= '0;

            // last row captured at this edge, so fire the columns now
            wr.longFrameStrobe <= wr.rowSelect[`NUMBER_OF_ROWS-1];

            if (configValid) begin
                case (state)
                    StUnsynced: begin
                        if (isSyncWord) begin
                            state <= StExpectAddress;
                        end
                    end

                    StExpectAddress: begin
                        if (isDesync) begin
                            state <= StUnsynced;
                        end else begin
                            state    <= StLoadData;
                            rowCount <= '0;
                        end
                    end

                    StLoadData: begin
                        wr.rowSelect <= cfgPkg::rowSelectT'(1) << rowCount;
                        if (rowCount == LastRow) begin
                            state    <= StExpectAddress;
                            rowCount <= '0;
                        end else begin
                            rowCount <= rowCount + 1'b1;
                        end
                    end

                    default: begin
                        state <= StUnsynced;
                    end
                endcase
            end
        end
    end

    // payload, qualified by the control path above
    always_ff @(posedge CLK) begin
        if (acceptData) begin
            wr.writeData <= configWord;
        end
        // address stays put until the next real frame
        if (acceptAddress) begin
            wr.frameAddress <= configWord;
        end
    end

endmodule

// ==== src/frameWriteIf.sv ====
`timescale 1ns/1ps

interface frameWriteIf;

    // data word and the row that takes it
    cfgPkg::cfgWordT   writeData;
    cfgPkg::rowSelectT rowSelect;

    // held address and the pulse that fires the column strobes
    cfgPkg::cfgWordT   frameAddress;
    logic              longFrameStrobe;

    modport ctrl (
        output writeData,
        output rowSelect,
        output frameAddress,
        output longFrameStrobe
    );

    modport rows (
        input writeData,
        input rowSelect
    );

    modport cols (
        input frameAddress,
        input longFrameStrobe
    );

endinterface
